// ==== hdl/snd_pkg.sv ====
//====================
// sound board types
// bus vectors, sample widths, gains
// sound and main bus structs
//====================

package snd_pkg;

    // plain vectors
    typedef logic [7:0]         byte_t;         // data byte, either bus
    typedef logic [15:0]        snd_addr_t;     // sound cpu address
    typedef logic [9:0]         shared_addr_t;  // shared memory / main bus address
    typedef logic [2:0]         bank_t;         // rom bank number
    typedef logic [16:0]        rom_addr_t;     // bank + 14 offset bits

    // audio
    typedef logic signed [15:0] sample_t;       // fm input, mixer output
    typedef logic signed [10:0] pcm_t;          // raw pcm sample
    typedef logic [7:0]         gain_t;         // 4.4 unsigned, 8'h10 is unity

    // sound processor bus, as seen at the board edge
    typedef struct packed {
        snd_addr_t addr;
        logic      rnw;     // high for read
        byte_t     dout;    // write data from the cpu
        logic      vma;     // access valid this cycle
    } snd_bus_t;

    // main/sub cpu side of the shared memory
    typedef struct packed {
        logic         cs;
        logic         rnw;
        shared_addr_t addr;
        byte_t        dout;
    } main_bus_t;

endpackage

// ==== hdl/snd_bus_decode.sv ====
`timescale 1ns/10ps
//====================
// sound bus address decoder
// rom bank register, vblank irq latch
// registered read data mux
//====================

module snd_bus_decode import snd_pkg::*; (
    input  logic      clk,
    input  logic      srst_n,
    input  snd_bus_t  snd_bus,
    input  logic      lvbl,
    input  byte_t     rom_data,
    input  logic      rom_ok,
    input  byte_t     ram_dout,
    input  byte_t     fm_dout,
    input  byte_t     tri_dout,
    input  byte_t     snd_rdata,
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    output logic      bus_busy,
    output logic      fm_cs,
    output logic      tri_cs,
    output logic      ram_we,
    output logic      shared_cs,
    output logic      irq_n,
    output byte_t     snd_din
);

    logic  ram_cs;      // work ram, read or write
    logic  reg_cs;      // control register writes
    bank_t bank;
    logic  lvbl_l;

    // select of the access in flight, one cycle late
    logic  rom_q;
    logic  ram_q;
    logic  fm_q;
    logic  tri_q;
    logic  shr_q;

    // one-hot decode on the top nibble
    always_comb begin
        rom_cs    = 1'b0;
        fm_cs     = 1'b0;
        shared_cs = 1'b0;
        tri_cs    = 1'b0;
        ram_cs    = 1'b0;
        reg_cs    = 1'b0;
        if (snd_bus.vma) begin
            casez (snd_bus.addr[15:12])
                4'b00??: rom_cs    = 1'b1;
                4'b0100: fm_cs     = 1'b1;
                4'b0101: shared_cs = 1'b1;
                4'b0111: tri_cs    = 1'b1;
                4'b100?: ram_cs    = 1'b1;
                4'b11??: begin
                    // top 16 KB is fixed rom for reads, registers for writes
                    rom_cs = snd_bus.rnw;
                    reg_cs = ~snd_bus.rnw;
                end
                default: ;  // 6000-6fff, a000-bfff unmapped
            endcase
        end
    end

    // top region always maps to bank 0
    assign rom_addr = {(&snd_bus.addr[15:14]) ? bank_t'(0) : bank, snd_bus.addr[13:0]};
    assign bus_busy = rom_cs & ~rom_ok;
    assign ram_we   = ram_cs & ~snd_bus.rnw;

    // bank register and vblank interrupt
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            bank   <= '0;
            irq_n  <= 1'b1;
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (!lvbl && lvbl_l)
                irq_n <= 1'b0;          // entering vblank
            if (reg_cs) begin
                case (snd_bus.addr[13:12])
                    2'd0:    bank  <= snd_bus.dout[6:4];
                    2'd2:    irq_n <= 1'b1;     // irq acknowledge
                    default: ;
                endcase
            end
        end
    end

    // first stage: remember who was selected, memory reads meanwhile
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            rom_q <= 1'b0;
            ram_q <= 1'b0;
            fm_q  <= 1'b0;
            tri_q <= 1'b0;
            shr_q <= 1'b0;
        end else begin
            rom_q <= rom_cs;
            ram_q <= ram_cs;
            fm_q  <= fm_cs;
            tri_q <= tri_cs;
            shr_q <= shared_cs;
        end
    end

    // second stage: read byte back to the cpu
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            snd_din <= '0;
        end else begin
            snd_din <= rom_q ? rom_data  :
                       ram_q ? ram_dout  :
                       fm_q  ? fm_dout   :
                       tri_q ? tri_dout  :
                       shr_q ? snd_rdata :
                       8'd0;
        end
    end

endmodule

// ==== hdl/snd_shared_ram.sv ====
`timescale 1ns/10ps
//====================
// 1 KB dual-port shared memory
// main/sub bus on one side, sound bus on the other
//====================

module snd_shared_ram import snd_pkg::*; (
    input  logic         clk,
    // main/sub cpu port
    input  main_bus_t    main_bus,
    output byte_t        c30_dout,
    // sound cpu port
    input  logic         snd_cs,
    input  logic         snd_rnw,
    input  shared_addr_t snd_addr,
    input  byte_t        snd_wdata,
    output byte_t        snd_rdata
);

    localparam int DEPTH = 1024;

    byte_t mem [DEPTH];

    logic main_we;
    logic snd_we;
    logic collide;

    assign snd_we  = snd_cs & ~snd_rnw;
    assign collide = snd_we & (snd_addr == main_bus.addr);

    // sound side wins when both write the same byte
    assign main_we = main_bus.cs & ~main_bus.rnw & ~collide;

    // writes
    always_ff @(posedge clk) begin
        if (main_we)
            mem[main_bus.addr] <= main_bus.dout;
        if (snd_we)
            mem[snd_addr] <= snd_wdata;
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (main_bus.cs)
            c30_dout <= mem[main_bus.addr];
    end

    always_ff @(posedge clk) begin
        if (snd_cs)
            snd_rdata <= mem[snd_addr];
    end

endmodule

// ==== hdl/snd_mixer.sv ====
`timescale 1ns/10ps
//====================
// two-input gain mixer
// fm + pcm, 4.4 gains, saturation
// and peak flag
//====================

module snd_mixer import snd_pkg::*; #(
    parameter gain_t FM_GAIN  = 8'h10,
    parameter gain_t PCM_GAIN = 8'h10
) (
    input  logic    clk,
    input  logic    srst_n,
    input  sample_t fm_in,
    input  pcm_t    pcm_in,
    output sample_t mixed,
    output logic    peak
);

    localparam logic signed [25:0] MAX_S = 26'sd32767;
    localparam logic signed [25:0] MIN_S = -26'sd32768;

    sample_t           pcm_ext;     // pcm at 16-bit scale
    logic signed [24:0] fm_prod;
    logic signed [24:0] pcm_prod;
    logic signed [25:0] mix_sum;
    logic signed [25:0] mix_div;
    sample_t           mix_sat;
    logic              sat;

    // 11 bits shifted up by 5 fill the 16-bit word exactly
    assign pcm_ext = {pcm_in, 5'b0};

    // gains are unsigned, so a zero msb keeps them positive
    assign fm_prod  = fm_in   * $signed({1'b0, FM_GAIN});
    assign pcm_prod = pcm_ext * $signed({1'b0, PCM_GAIN});

    assign mix_sum = fm_prod + pcm_prod;
    assign mix_div = mix_sum >>> 4;     // drop the 4 fraction bits

    // clamp to the 16-bit range
    always_comb begin
        if (mix_div > MAX_S) begin
            mix_sat = 16'sh7fff;
            sat     = 1'b1;
        end else if (mix_div < MIN_S) begin
            mix_sat = -16'sh8000;
            sat     = 1'b1;
        end else begin
            mix_sat = mix_div[15:0];
            sat     = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else begin
            mixed <= mix_sat;
            peak  <= sat;
        end
    end

endmodule

// ==== hdl/snd_board.sv ====
`timescale 1ns/10ps
//====================
// sound board top level
// bus decoder, shared memory and
// left/right mixers with sample latch
//====================

module snd_board import snd_pkg::*; #(
    parameter gain_t FM_GAIN  = 8'd16,  // 1.0
    parameter gain_t PCM_GAIN = 8'd16
) (
    input  logic      clk,
    input  logic      srst_n,
    // sound cpu bus
    input  snd_bus_t  snd_bus,
    input  logic      lvbl,
    input  byte_t     rom_data,
    input  logic      rom_ok,
    input  byte_t     ram_dout,
    input  byte_t     fm_dout,
    input  byte_t     tri_dout,
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    output logic      bus_busy,
    output logic      fm_cs,
    output logic      tri_cs,
    output logic      ram_we,
    output logic      shared_cs,
    output logic      irq_n,
    output byte_t     snd_din,
    // main/sub bus
    input  main_bus_t main_bus,
    output byte_t     c30_dout,
    // audio
    input  sample_t   fm_l,
    input  sample_t   fm_r,
    input  pcm_t      pcm_snd,
    input  logic      fm_sample,
    output sample_t   left,
    output sample_t   right,
    output logic      sample,
    output logic      peak
);

    byte_t   snd_rdata;
    sample_t mix_l;
    sample_t mix_r;
    logic    peak_l;
    logic    peak_r;
    logic    fm_sample_q;   // mixers hold the new result one cycle later

    snd_bus_decode u_decode (
        .clk       ( clk       ),
        .srst_n    ( srst_n    ),
        .snd_bus   ( snd_bus   ),
        .lvbl      ( lvbl      ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_dout  ( ram_dout  ),
        .fm_dout   ( fm_dout   ),
        .tri_dout  ( tri_dout  ),
        .snd_rdata ( snd_rdata ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .bus_busy  ( bus_busy  ),
        .fm_cs     ( fm_cs     ),
        .tri_cs    ( tri_cs    ),
        .ram_we    ( ram_we    ),
        .shared_cs ( shared_cs ),
        .irq_n     ( irq_n     ),
        .snd_din   ( snd_din   )
    );

    snd_shared_ram u_shared (
        .clk       ( clk                ),
        .main_bus  ( main_bus           ),
        .c30_dout  ( c30_dout           ),
        .snd_cs    ( shared_cs          ),
        .snd_rnw   ( snd_bus.rnw        ),
        .snd_addr  ( snd_bus.addr[9:0]  ),  // 1 KB window, upper bits mirror
        .snd_wdata ( snd_bus.dout       ),
        .snd_rdata ( snd_rdata          )
    );

    snd_mixer #(.FM_GAIN(FM_GAIN), .PCM_GAIN(PCM_GAIN)) u_left (
        .clk    ( clk     ),
        .srst_n ( srst_n  ),
        .fm_in  ( fm_l    ),
        .pcm_in ( pcm_snd ),
        .mixed  ( mix_l   ),
        .peak   ( peak_l  )
    );

    snd_mixer #(.FM_GAIN(FM_GAIN), .PCM_GAIN(PCM_GAIN)) u_right (
        .clk    ( clk     ),
        .srst_n ( srst_n  ),
        .fm_in  ( fm_r    ),
        .pcm_in ( pcm_snd ),
        .mixed  ( mix_r   ),
        .peak   ( peak_r  )
    );

    // outputs move only on a new fm sample, sample flags the update
    always_ff @(posedge clk or negedge srst_n) begin
        if (!srst_n) begin
            fm_sample_q <= 1'b0;
            sample      <= 1'b0;
            left        <= '0;
            right       <= '0;
            peak        <= 1'b0;
        end else begin
            fm_sample_q <= fm_sample;
            sample      <= fm_sample_q;
            if (fm_sample_q) begin
                left  <= mix_l;
                right <= mix_r;
                peak  <= peak_l | peak_r;   // either channel clipped
            end
        end
    end

endmodule

// ==== verification/snd_board_tb.sv ====
`timescale 1ns/10ps
//====================
// sound board testbench
// golden file steps on both buses
// and the left/right mixers
//====================

module snd_board_tb import snd_pkg::*; ();

    localparam string GOLDEN = "verification/snd_golden.txt";

    // one golden line as hex columns in file order
    typedef struct packed {
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] ctl;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic [31:0] exp2;
    } step_t;

    logic      clk;
    logic      srst_n;
    snd_bus_t  snd_bus;
    logic      lvbl;
    byte_t     rom_data;
    logic      rom_ok;
    byte_t     ram_dout;
    byte_t     fm_dout;
    byte_t     tri_dout;
    logic      rom_cs;
    rom_addr_t rom_addr;
    logic      bus_busy;
    logic      fm_cs;
    logic      tri_cs;
    logic      ram_we;
    logic      shared_cs;
    logic      irq_n;
    byte_t     snd_din;
    main_bus_t main_bus;
    byte_t     c30_dout;
    sample_t   fm_l;
    sample_t   fm_r;
    pcm_t      pcm_snd;
    logic      fm_sample;
    sample_t   left;
    sample_t   right;
    logic      sample;
    logic      peak;

    step_t steps[$];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    int    limit  = 0;      // armed once the golden file is loaded

    snd_board DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // rom fm shared tri ram_we busy from the msb down
    function automatic logic [31:0] selects();
        return {26'd0, rom_cs, fm_cs, shared_cs, tri_cs, ram_we, bus_busy};
    endfunction

    task automatic release_bus();
        snd_bus.addr  = 16'($urandom);
        snd_bus.dout  = 8'($urandom);
        snd_bus.rnw   = 1'b1;
        snd_bus.vma   = 1'b0;
        main_bus.cs   = 1'b0;
        main_bus.rnw  = 1'b1;
        main_bus.addr = 10'($urandom);
        main_bus.dout = 8'($urandom);
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        int    line_no;
        int    f [7];
        string line;
        step_t s;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("could not open %s", GOLDEN);
            errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n <= 1 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n != 7) begin
                $display("golden line %0d has %0d readable columns instead of 7", line_no, n);
                errors++;
            end else begin
                s = '{f[0], f[1], f[2], f[3], f[4], f[5], f[6]};
                steps.push_back(s);
            end
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            $display("golden file holds no steps");
            errors++;
        end
    endtask

    // sound access held for three cycles with selects checked after the first
    task automatic sound_access(input step_t s, input logic rnw);
        snd_bus.addr = s.addr[15:0];
        snd_bus.rnw  = rnw;
        snd_bus.dout = s.data[7:0];
        snd_bus.vma  = 1'b1;
        rom_ok       = s.ctl[0];
        rom_data     = s.data[7:0];
        ram_dout     = s.data[7:0] + 8'd1;
        fm_dout      = s.data[7:0] + 8'd2;
        tri_dout     = s.data[7:0] + 8'd3;
        @(negedge clk);
        check("selects", s.exp0, selects());
        if (rnw)
            check("rom_addr", s.exp1, 32'(rom_addr));
        else
            check("irq_n", s.exp1, 32'(irq_n));    // bank and irq already updated
        @(negedge clk);
        if (rnw)
            check("snd_din", s.exp2, 32'(snd_din));
        @(negedge clk);
        release_bus();
        rom_ok = 1'b1;
    endtask

    task automatic main_access(input step_t s, input logic rnw);
        main_bus.cs   = 1'b1;
        main_bus.rnw  = rnw;
        main_bus.addr = s.addr[9:0];
        main_bus.dout = s.data[7:0];
        @(negedge clk);
        if (rnw)
            check("c30_dout", s.exp0, 32'(c30_dout));
        release_bus();
    endtask

    // both sides write the same byte with sound data in data and main data in ctl
    task automatic write_collision(input step_t s);
        main_bus.cs   = 1'b1;
        main_bus.rnw  = 1'b0;
        main_bus.addr = s.addr[9:0];
        main_bus.dout = s.ctl[7:0];
        snd_bus.addr  = {6'b010100, s.addr[9:0]};
        snd_bus.rnw   = 1'b0;
        snd_bus.dout  = s.data[7:0];
        snd_bus.vma   = 1'b1;
        @(negedge clk);
        check("shared_cs", 32'd1, 32'(shared_cs));
        release_bus();
    endtask

    task automatic mix_sample(input step_t s);
        fm_l      = s.addr[15:0];
        fm_r      = s.data[15:0];
        pcm_snd   = s.ctl[10:0];
        fm_sample = 1'b1;
        @(negedge clk);
        fm_sample = 1'b0;
        check("sample", 32'd0, 32'(sample));
        @(negedge clk);
        check("left", s.exp0, 32'($unsigned(left)));
        check("right", s.exp1, 32'($unsigned(right)));
        check("peak", s.exp2, 32'(peak));
        check("sample", 32'd1, 32'(sample));
        @(negedge clk);
        check("sample", 32'd0, 32'(sample));     // single pulse
    endtask

    task automatic run_step(input int idx, input step_t s);
        case (s.op)
            0: main_access(s, 1'b0);
            1: main_access(s, 1'b1);
            2: sound_access(s, 1'b0);
            3: sound_access(s, 1'b1);
            4: begin
                lvbl = s.ctl[0];
                repeat (2) @(negedge clk);
                check("irq_n", s.exp0, 32'(irq_n));
            end
            5: mix_sample(s);
            6: write_collision(s);
            default: begin
                $display("golden step %0d has unknown operation %0d", idx, s.op);
                errors++;
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'hf55d));
        srst_n    = 1'b0;
        lvbl      = 1'b1;
        rom_data  = '0;
        rom_ok    = 1'b1;
        ram_dout  = '0;
        fm_dout   = '0;
        tri_dout  = '0;
        fm_l      = '0;
        fm_r      = '0;
        pcm_snd   = '0;
        fm_sample = 1'b0;
        release_bus();
        load_golden();
        limit = 4 * steps.size() + 100;

        repeat (2) @(posedge clk);
        @(negedge clk);
        srst_n = 1'b1;
        check("irq_n", 32'd1, 32'(irq_n));
        check("snd_din", 32'd0, 32'(snd_din));
        check("left", 32'd0, 32'($unsigned(left)));
        check("right", 32'd0, 32'($unsigned(right)));
        check("peak", 32'd0, 32'(peak));
        check("sample", 32'd0, 32'(sample));

        foreach (steps[i])
            run_step(i, steps[i]);

        $display("closing: %0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/snd_pkg.sv
hdl/snd_bus_decode.sv
hdl/snd_shared_ram.sv
hdl/snd_mixer.sv
hdl/snd_board.sv
verification/snd_board_tb.sv

// ==== Makefile ====
# Verilator build and run of the sound board testbench

SRCS = hdl/snd_pkg.sv hdl/snd_bus_decode.sv hdl/snd_shared_ram.sv \
       hdl/snd_mixer.sv hdl/snd_board.sv verification/snd_board_tb.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vsnd_board_tb: list.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module snd_board_tb -f list.f

run: obj_dir/Vsnd_board_tb
	./obj_dir/Vsnd_board_tb | tee sim.log
	grep -qx 'Test passed' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/snd_golden.txt ====
# op addr data ctl exp0 exp1 exp2, all hex; ops 0 main wr, 1 main rd, 2 snd wr, 3 snd rd,
# 4 vblank (ctl lvbl, exp0 irq_n), 5 mix (fm_l fm_r pcm left right peak), 6 write collision
3 0123 a5 1 20 00123 a5
3 0123 a5 0 21 00123 a5
3 2abc 0f 1 20 02abc 0f
3 4001 30 1 10 00001 32
3 7002 40 1 04 03002 43
3 8003 50 1 00 00003 51
3 6000 60 1 00 02000 00
3 a000 70 1 00 02000 00
3 c234 80 1 20 00234 80
3 c234 80 0 21 00234 80
2 8100 99 0 02 1 0
2 9fff 55 0 02 1 0
2 4000 12 0 10 1 0
2 7001 34 0 04 1 0
0 0010 3c 0 0 0 0
3 5010 00 1 08 01010 3c
0 03ff e1 0 0 0 0
3 53ff 00 1 08 013ff e1
2 5020 c7 0 08 1 0
1 0020 00 0 c7 0 0
6 0030 5a a5 0 0 0
1 0030 00 0 5a 0 0
3 5030 00 1 08 01030 5a
4 0000 00 0 0 0 0
4 0000 00 1 0 0 0
2 d000 00 0 00 0 0
2 e000 00 0 00 1 0
4 0000 00 1 1 0 0
2 c000 50 0 00 1 0
3 1234 11 1 20 15234 11
3 f000 22 1 20 03000 22
2 c000 70 0 00 1 0
3 3fff 33 0 21 1ffff 33
2 c000 00 0 00 1 0
3 1234 44 1 20 01234 44
5 1000 f000 010 1200 f200 0
5 7000 0100 200 7fff 4100 1
5 8000 0000 600 8000 c000 1
5 0123 0456 7ff 0103 0436 0
